//--- baud_gen.sv
module baud_gen (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                div_wr,
    input  logic [spart_reg_pkg::addr_w-1:0]    ioaddr,
    input  logic [spart_reg_pkg::data_w-1:0]    divisor,
    output logic                                en
);

    logic [spart_reg_pkg::div_w-1:0]    div_q;
    logic [spart_reg_pkg::div_w-1:0]    div_next;
    logic [spart_reg_pkg::div_w-1:0]    cnt;

    ////////////////////////////////////////////////////////////
    // Divisor register
    ////////////////////////////////////////////////////////////

    // Merge the written byte into the current divisor
    always_comb begin
        div_next = div_q;
        if (ioaddr == spart_reg_pkg::addr_div_hi) begin
            div_next[spart_reg_pkg::div_w-1:spart_reg_pkg::data_w] = divisor;
        end else begin
            div_next[spart_reg_pkg::data_w-1:0] = divisor;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_q <= spart_reg_pkg::div_reset;
        end else if (div_wr) begin
            div_q <= div_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Oversample down-counter
    ////////////////////////////////////////////////////////////

    // Pulse once per divisor+1 clocks
    assign en = (cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= spart_reg_pkg::div_reset;
        end else if (div_wr) begin
            // Restart the period on a new divisor
            cnt <= div_next;
        end else if (en) begin
            cnt <= div_q;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- bus_interface.sv
module bus_interface (
    input  logic                                iocs,
    input  logic                                iorw,
    input  logic [spart_reg_pkg::addr_w-1:0]    ioaddr,
    inout  wire  [spart_reg_pkg::data_w-1:0]    databus,
    input  logic [spart_reg_pkg::data_w-1:0]    rx_data,
    input  logic                                tbr,
    input  logic                                rda,
    output logic                                transmit,
    output logic                                clr_rda,
    output logic                                div_wr,
    output logic [spart_reg_pkg::data_w-1:0]    tx_data
);

    ////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////

    logic                               rd_acc;
    logic                               wr_acc;
    logic [spart_reg_pkg::data_w-1:0]   status_byte;
    logic [spart_reg_pkg::data_w-1:0]   rd_data;

    // iorw high is a read
    assign rd_acc = iocs && iorw;
    assign wr_acc = iocs && !iorw;

    // Data write loads the TX buffer
    assign transmit = wr_acc && (ioaddr == spart_reg_pkg::addr_data);
    // Data read consumes the received byte
    assign clr_rda  = rd_acc && (ioaddr == spart_reg_pkg::addr_data);
    // Either divisor byte
    assign div_wr   = wr_acc && ((ioaddr == spart_reg_pkg::addr_div_lo) ||
                                 (ioaddr == spart_reg_pkg::addr_div_hi));

    // Write data straight off the bus, shared by TX and baud_gen
    assign tx_data = databus;

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    // Unused status bits read as zero
    always_comb begin
        status_byte = '0;
        status_byte[spart_reg_pkg::status_tbr_bit] = tbr;
        status_byte[spart_reg_pkg::status_rda_bit] = rda;
    end

    always_comb begin
        case (ioaddr)
            spart_reg_pkg::addr_data:   rd_data = rx_data;
            spart_reg_pkg::addr_status: rd_data = status_byte;
            // Divisor is write only
            default:                    rd_data = '0;
        endcase
    end

    // Drive the bus only during a read, float otherwise
    assign databus = rd_acc ? rd_data : 'z;

endmodule

//--- list.f
spart_reg_pkg.sv
spart_line_pkg.sv
bus_interface.sv
baud_gen.sv
tx_unit.sv
rx_unit.sv
spart.sv
tb_spart.sv

//--- run.sh
#!/bin/sh
# Build and run the SPART testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_spart -f list.f \
    && ./obj_dir/Vtb_spart \
    || { echo "simulation failed"; exit 1; }

//--- rx_unit.sv
module rx_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                rx_en,
    input  logic                                rxd,
    input  logic                                clr_rda,
    output logic [spart_reg_pkg::data_w-1:0]    rx_data,
    output logic                                rda
);

    localparam logic [spart_line_pkg::bit_idx_w-1:0] idx_last =
        spart_line_pkg::bit_idx_w'(spart_reg_pkg::data_w - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t                              state;
    logic                                   rxd_meta;
    logic                                   rxd_s;
    logic                                   rxd_last;
    logic                                   at_sample;
    logic [spart_line_pkg::os_cnt_w-1:0]    tick;
    logic [spart_line_pkg::bit_idx_w-1:0]   bit_idx;
    logic [spart_reg_pkg::data_w-1:0]       shift_q;

    ////////////////////////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= spart_line_pkg::line_idle;
            rxd_s    <= spart_line_pkg::line_idle;
            rxd_last <= spart_line_pkg::line_idle;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            // Previous line value as seen at the last enable
            if (rx_en) begin
                rxd_last <= rxd_s;
            end
        end
    end

    // Mid-bit sample point
    assign at_sample = rx_en && (tick == spart_line_pkg::sample_tick);

    ////////////////////////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            tick    <= '0;
            bit_idx <= '0;
            rda     <= 1'b0;
        end else begin
            // Data read consumes the byte
            if (clr_rda) begin
                rda <= 1'b0;
            end
            if (rx_en) begin
                case (state)
                    st_idle: begin
                        // Falling edge opens a frame
                        if (rxd_last == spart_line_pkg::line_idle &&
                            rxd_s != spart_line_pkg::line_idle) begin
                            state <= st_start;
                            tick  <= '0;
                        end
                    end
                    st_start: begin
                        tick <= tick + 1'b1;
                        if (at_sample) begin
                            // Glitch, not a real start bit
                            if (rxd_s == spart_line_pkg::line_idle) begin
                                state <= st_idle;
                            end else begin
                                state   <= st_data;
                                bit_idx <= '0;
                            end
                        end
                    end
                    st_data: begin
                        tick <= tick + 1'b1;
                        if (at_sample) begin
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == idx_last) begin
                                state <= st_stop;
                            end
                        end
                    end
                    st_stop: begin
                        tick <= tick + 1'b1;
                        if (at_sample) begin
                            state <= st_idle;
                            // Good stop bit wins over a same-cycle clear
                            if (rxd_s == spart_line_pkg::line_idle) begin
                                rda <= 1'b1;
                            end
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (at_sample && state == st_data) begin
            shift_q <= {rxd_s, shift_q[spart_reg_pkg::data_w-1:1]};
        end
        // Bad stop bit drops the frame
        if (at_sample && state == st_stop && rxd_s == spart_line_pkg::line_idle) begin
            rx_data <= shift_q;
        end
    end

endmodule

//--- spart.sv
module spart (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                iocs,
    input  logic                                iorw,
    input  logic [spart_reg_pkg::addr_w-1:0]    ioaddr,
    inout  wire  [spart_reg_pkg::data_w-1:0]    databus,
    output logic                                rda,
    output logic                                tbr,
    output logic                                txd,
    input  logic                                rxd
);

    ////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////

    // Strobes from the bus decode
    logic                               transmit;
    logic                               clr_rda;
    logic                               div_wr;
    // Write data, both TX byte and divisor byte
    logic [spart_reg_pkg::data_w-1:0]   tx_data;
    // 16x oversample enable
    logic                               en;
    // Last good received byte
    logic [spart_reg_pkg::data_w-1:0]   rx_data;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    // Processor side
    bus_interface i_bus_interface (
        .iocs     (iocs),
        .iorw     (iorw),
        .ioaddr   (ioaddr),
        .databus  (databus),
        .rx_data  (rx_data),
        .tbr      (tbr),
        .rda      (rda),
        .transmit (transmit),
        .clr_rda  (clr_rda),
        .div_wr   (div_wr),
        .tx_data  (tx_data)
    );

    // Baud rate
    baud_gen i_baud_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .div_wr  (div_wr),
        .ioaddr  (ioaddr),
        .divisor (tx_data),
        .en      (en)
    );

    // Transmit channel
    tx_unit i_tx_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_en    (en),
        .transmit (transmit),
        .tx_data  (tx_data),
        .tbr      (tbr),
        .txd      (txd)
    );

    // Receive channel
    rx_unit i_rx_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_en   (en),
        .rxd     (rxd),
        .clr_rda (clr_rda),
        .rx_data (rx_data),
        .rda     (rda)
    );

endmodule

//--- spart_line_pkg.sv
package spart_line_pkg;

    ////////////////////////////////////////////////////////////
    // Serial line format, 8N1
    ////////////////////////////////////////////////////////////

    // Enable pulses per serial bit
    localparam int os_ratio = 16;
    // Oversample tick counter width
    localparam int os_cnt_w = 4;

    // Mid-bit sample point within a bit
    localparam logic [os_cnt_w-1:0] sample_tick = os_cnt_w'(7);

    // Start bit, eight data bits, stop bit
    localparam int frame_bits = 10;
    // Bit index counter width
    localparam int bit_idx_w = 4;

    // Idle line level, also the stop bit level
    localparam logic line_idle = 1'b1;

endpackage

//--- spart_reg_pkg.sv
package spart_reg_pkg;

    ////////////////////////////////////////////////////////////
    // Processor bus
    ////////////////////////////////////////////////////////////

    // Data bus width, also the width of one serial character
    localparam int data_w = 8;
    // Register select width
    localparam int addr_w = 2;

    // Register map
    localparam logic [addr_w-1:0] addr_data   = addr_w'(0);
    localparam logic [addr_w-1:0] addr_status = addr_w'(1);
    localparam logic [addr_w-1:0] addr_div_lo = addr_w'(2);
    localparam logic [addr_w-1:0] addr_div_hi = addr_w'(3);

    // Status byte layout
    localparam int status_tbr_bit = 0;
    localparam int status_rda_bit = 1;

    // Baud divisor
    localparam int div_w = 16;
    // Small reset divisor, fast enough for simulation
    localparam logic [div_w-1:0] div_reset = div_w'(7);

endpackage

//--- tb_spart.sv
module tb_spart;

    // Test divisor and the bit timing that follows from it
    localparam int dw             = spart_reg_pkg::data_w;
    localparam logic [dw-1:0] test_div = dw'(3);
    localparam int en_clks        = int'(test_div) + 1;
    localparam int bit_clks       = spart_line_pkg::os_ratio * en_clks;
    localparam int frame_clks     = spart_line_pkg::frame_bits * bit_clks;
    // About 13 frames of traffic, budget 20 plus slack
    localparam int timeout_margin = 1000;
    localparam int max_cycles     = 20 * frame_clks + timeout_margin;
    localparam int loop_bytes     = 8;

    // Expected status bytes from the register map
    localparam logic [dw-1:0] status_idle = dw'(1 << spart_reg_pkg::status_tbr_bit);
    localparam logic [dw-1:0] status_full =
        status_idle | dw'(1 << spart_reg_pkg::status_rda_bit);

    logic                               clk;
    logic                               rst_n;
    logic                               iocs;
    logic                               iorw;
    logic [spart_reg_pkg::addr_w-1:0]   ioaddr;
    wire  [dw-1:0]                      databus;
    logic                               rda;
    logic                               tbr;
    logic                               txd;
    logic                               rxd;
    // Serial driver output and loopback select
    logic                               tb_rxd;
    logic                               loop_sel;
    // Processor side of the tri-state bus
    logic                               drive_en;
    logic [dw-1:0]                      drive_q;
    int                                 cycle_cnt = 0;
    int                                 seed;

    assign databus = drive_en ? drive_q : 'z;
    assign rxd     = loop_sel ? txd : tb_rxd;

    spart i_spart (
        .clk     (clk),
        .rst_n   (rst_n),
        .iocs    (iocs),
        .iorw    (iorw),
        .ioaddr  (ioaddr),
        .databus (databus),
        .rda     (rda),
        .tbr     (tbr),
        .txd     (txd),
        .rxd     (rxd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Error reporting and checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [dw-1:0] exp,
                                   input logic [dw-1:0] act);
        abort_run($sformatf("mismatch at %0t: %s expected %h actual %h",
                            $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act == exp) else report_mismatch(name, dw'(exp), dw'(act));
    endtask

    task automatic check_byte(input string name, input logic [dw-1:0] exp,
                              input logic [dw-1:0] act);
        assert (act == exp) else report_mismatch(name, exp, act);
    endtask

    // Line only leaves idle while the TX buffer is busy
    tx_busy_chk: assert property (@(posedge clk) disable iff (!rst_n) !txd |-> !tbr)
        else report_mismatch("tbr", '0, dw'(tbr));

    // SPART must float the bus while the processor writes
    wr_bus_chk: assert property (@(posedge clk) disable iff (!rst_n)
                                 (iocs && !iorw) |-> databus == drive_q)
        else report_mismatch("databus", drive_q, databus);

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > max_cycles) begin
            abort_run($sformatf("timeout: run passed %0d cycles", max_cycles));
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus and serial tasks
    ////////////////////////////////////////////////////////////

    // One-cycle write, takes effect at the closing edge
    task automatic bus_write(input logic [spart_reg_pkg::addr_w-1:0] addr,
                             input logic [dw-1:0] val);
        @(posedge clk);
        iocs     <= 1'b1;
        iorw     <= 1'b0;
        ioaddr   <= addr;
        drive_en <= 1'b1;
        drive_q  <= val;
        @(posedge clk);
        iocs     <= 1'b0;
        drive_en <= 1'b0;
    endtask

    // Read data sampled mid-cycle while the DUT drives
    task automatic bus_read(input logic [spart_reg_pkg::addr_w-1:0] addr,
                            output logic [dw-1:0] val);
        @(posedge clk);
        iocs   <= 1'b1;
        iorw   <= 1'b1;
        ioaddr <= addr;
        @(negedge clk);
        val = databus;
        @(posedge clk);
        iocs <= 1'b0;
    endtask

    task automatic wait_tbr_high(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (tbr != 1'b1) begin
            n++;
            assert (n <= limit) else abort_run("tbr never came back high");
            @(negedge clk);
        end
    endtask

    task automatic wait_rda_high(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (rda != 1'b1) begin
            n++;
            assert (n <= limit) else abort_run("rda never rose after a frame");
            @(negedge clk);
        end
    endtask

    // 8N1 frame at the test rate, LSB first
    task automatic send_serial(input logic [dw-1:0] val, input logic stop_level);
        logic [spart_line_pkg::frame_bits-1:0] frame;
        frame = {stop_level, val, 1'b0};
        repeat (spart_line_pkg::frame_bits) begin
            @(posedge clk);
            tb_rxd <= frame[0];
            frame = frame >> 1;
            repeat (bit_clks - 1) @(posedge clk);
        end
        @(posedge clk);
        tb_rxd <= 1'b1;
    endtask

    // Entered at the negedge right after the write edge
    task automatic check_tx_frame(input logic [dw-1:0] val);
        logic [spart_line_pkg::frame_bits-1:0] frame;
        int n;
        int k;
        frame = {1'b1, val, 1'b0};
        n = 0;
        // Start bit within one en period
        while (txd == 1'b1) begin
            @(negedge clk);
            n++;
            assert (n <= en_clks) else abort_run("txd start bit came too late");
        end
        // Move to the first bit center
        repeat (bit_clks / 2 - 1) @(negedge clk);
        for (k = 0; k < spart_line_pkg::frame_bits; k++) begin
            check_bit("txd", frame[0], txd);
            frame = frame >> 1;
            if (k < spart_line_pkg::frame_bits - 1) begin
                repeat (bit_clks) @(negedge clk);
            end
        end
        // Still busy in the middle of the stop bit
        check_bit("tbr", 1'b0, tbr);
        wait_tbr_high(bit_clks);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [dw-1:0] rd_val;
        logic [dw-1:0] exp_val;
        int rnd;
        int i;
        seed = 82869;
        rst_n    <= 1'b0;
        iocs     <= 1'b0;
        iorw     <= 1'b0;
        ioaddr   <= '0;
        drive_en <= 1'b0;
        drive_q  <= '0;
        tb_rxd   <= 1'b1;
        loop_sel <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_bit("txd", 1'b1, txd);
        check_bit("tbr", 1'b1, tbr);
        check_bit("rda", 1'b0, rda);
        bus_read(spart_reg_pkg::addr_status, rd_val);
        check_byte("status", status_idle, rd_val);
        // Idle bus passes tb patterns untouched
        @(posedge clk);
        drive_en <= 1'b1;
        drive_q  <= '0;
        @(negedge clk);
        check_byte("databus", '0, databus);
        @(posedge clk);
        drive_q <= '1;
        @(negedge clk);
        check_byte("databus", '1, databus);
        @(posedge clk);
        drive_en <= 1'b0;

        // Program the divisor, then one TX frame
        bus_write(spart_reg_pkg::addr_div_lo, test_div);
        bus_write(spart_reg_pkg::addr_div_hi, '0);
        bus_write(spart_reg_pkg::addr_data, 8'ha5);
        @(negedge clk);
        check_bit("tbr", 1'b0, tbr);
        check_tx_frame(8'ha5);

        // Second write lands mid-frame and is dropped
        bus_write(spart_reg_pkg::addr_data, 8'h3c);
        @(negedge clk);
        fork
            check_tx_frame(8'h3c);
            begin
                repeat (3 * bit_clks) @(negedge clk);
                check_bit("tbr", 1'b0, tbr);
                bus_write(spart_reg_pkg::addr_data, 8'hc3);
            end
        join
        repeat (2 * bit_clks) begin
            @(negedge clk);
            check_bit("txd", 1'b1, txd);
            check_bit("tbr", 1'b1, tbr);
        end

        // Receive, then clear rda with a data read
        send_serial(8'h96, 1'b1);
        wait_rda_high(2 * en_clks);
        bus_read(spart_reg_pkg::addr_status, rd_val);
        check_byte("status", status_full, rd_val);
        bus_read(spart_reg_pkg::addr_data, rd_val);
        check_byte("rx_data", 8'h96, rd_val);
        @(negedge clk);
        check_bit("rda", 1'b0, rda);

        // Low stop bit, frame dropped
        send_serial(8'h5e, 1'b0);
        repeat (2 * bit_clks) begin
            @(negedge clk);
            check_bit("rda", 1'b0, rda);
        end
        send_serial(8'h47, 1'b1);
        wait_rda_high(2 * en_clks);
        bus_read(spart_reg_pkg::addr_data, rd_val);
        check_byte("rx_data", 8'h47, rd_val);

        // txd looped back into rxd
        @(posedge clk);
        loop_sel <= 1'b1;
        for (i = 0; i < loop_bytes; i++) begin
            rnd = $random(seed);
            exp_val = rnd[dw-1:0];
            wait_tbr_high(frame_clks + bit_clks);
            bus_write(spart_reg_pkg::addr_data, exp_val);
            wait_rda_high(frame_clks + 2 * bit_clks);
            bus_read(spart_reg_pkg::addr_data, rd_val);
            check_byte("loopback rx_data", exp_val, rd_val);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tx_unit.sv
module tx_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                tx_en,
    input  logic                                transmit,
    input  logic [spart_reg_pkg::data_w-1:0]    tx_data,
    output logic                                tbr,
    output logic                                txd
);

    localparam logic [spart_line_pkg::os_cnt_w-1:0] tick_last =
        spart_line_pkg::os_cnt_w'(spart_line_pkg::os_ratio - 1);
    localparam logic [spart_line_pkg::bit_idx_w-1:0] idx_last =
        spart_line_pkg::bit_idx_w'(spart_line_pkg::frame_bits - 1);

    logic                                       active;
    logic                                       waiting;
    logic                                       bit_done;
    logic [spart_line_pkg::os_cnt_w-1:0]        tick;
    logic [spart_line_pkg::bit_idx_w-1:0]       bit_idx;
    logic [spart_line_pkg::frame_bits-1:0]      frame_q;

    // Byte captured but frame not yet started
    assign waiting  = !tbr && !active;
    // Last tick of the current bit
    assign bit_done = active && tx_en && (tick == tick_last);

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tbr     <= 1'b1;
            active  <= 1'b0;
            tick    <= '0;
            bit_idx <= '0;
        end else if (transmit && tbr) begin
            // Buffer now full
            tbr <= 1'b0;
        end else if (waiting && tx_en) begin
            // Start bit goes out on this enable
            active  <= 1'b1;
            tick    <= '0;
            bit_idx <= '0;
        end else if (active && tx_en) begin
            tick <= tick + 1'b1;
            if (bit_done) begin
                if (bit_idx == idx_last) begin
                    // Stop bit finished
                    active <= 1'b0;
                    tbr    <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame shifter
    ////////////////////////////////////////////////////////////

    // Stop, data, start with start bit at the LSB
    always_ff @(posedge clk) begin
        if (transmit && tbr) begin
            frame_q <= {spart_line_pkg::line_idle, tx_data, ~spart_line_pkg::line_idle};
        end else if (bit_done) begin
            frame_q <= {spart_line_pkg::line_idle,
                        frame_q[spart_line_pkg::frame_bits-1:1]};
        end
    end

    // Line idles high outside a frame
    assign txd = active ? frame_q[0] : spart_line_pkg::line_idle;

endmodule
